/* mem_pipe.f */
+incdir+include
source/mem_op_pkg.sv
source/pipe_bus_pkg.sv
source/pipe_slot.sv
source/data_sram.sv
source/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/mem_pipe_top.sv
bench/mem_pipe_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module mem_pipe_tb -f mem_pipe.f -o mem_pipe_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/mem_pipe_sim > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* bench/mem_pipe_tb.sv */
`timescale 1ns/1ps
`include "mem_pipe_cfg.svh"

module mem_pipe_tb;
    import mem_op_pkg::*;
    import pipe_bus_pkg::*;

    localparam int PROG_LEN    = 400;
    localparam int MEM_BYTES   = `MEM_PIPE_WORDS * 4;
    localparam int AW          = $clog2(MEM_BYTES);
    localparam int WINDOW      = 64;  // small hot region so loads see earlier stores
    localparam int STALL_LIMIT = 4 * `MEM_PIPE_MAX_LAT + 16;
    localparam int CYCLE_LIMIT = PROG_LEN * 40;

    logic        clk;
    logic        resetn;
    logic        in_valid;
    logic        in_allowin;
    logic [31:0] in_pc;
    mem_op_t     in_op;
    logic [31:0] in_base;
    logic [31:0] in_offset;
    logic [31:0] in_wdata;
    logic [4:0]  in_rd;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic        wb_ex;
    logic [31:0] ex_pc;
    rf_fwd_t     fwd_out;

    integer      seed = 32'hada4;
    mem_op_t     prog_op [PROG_LEN];
    logic [31:0] prog_base [PROG_LEN];
    logic [31:0] prog_off [PROG_LEN];
    logic [31:0] prog_wdata [PROG_LEN];
    logic [4:0]  prog_rd [PROG_LEN];
    logic [7:0]  model_mem [MEM_BYTES];
    int          fly_idx [$]; // accepted and not yet retired, oldest first
    int          fly_cyc [$]; // cycle of acceptance
    int          drv_idx;
    bit          presenting;
    bit          fwd_armed;
    int          fwd_idx;
    rf_fwd_t     fwd_snap;
    int          cycle;
    int          stall;
    int          n_retired;
    int          n_ex;

    mem_pipe_top UUT (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_allowin(in_allowin), .in_pc(in_pc), .in_op(in_op),
        .in_base(in_base), .in_offset(in_offset), .in_wdata(in_wdata), .in_rd(in_rd),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_rd(retire_rd), .retire_wdata(retire_wdata),
        .wb_ex(wb_ex), .ex_pc(ex_pc), .fwd_out(fwd_out)
    );

    always #50 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "simulation stopped at cycle %0d", cycle);
    endtask

    function automatic logic [31:0] pc_of(input int idx);
        return 32'h0000_1000 + (32'(idx) << 2);
    endfunction

    function automatic logic [31:0] addr_of(input int idx);
        return prog_base[idx] + prog_off[idx];
    endfunction

    function automatic string name_of(input int idx);
        return $sformatf("%s #%0d", prog_op[idx].name(), idx);
    endfunction

    function automatic bit is_load(input int idx);
        return prog_op[idx] inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    endfunction

    function automatic bit misaligned(input int idx);
        logic [31:0] a;
        a = addr_of(idx);
        case (prog_op[idx])
            op_ld_h, op_ld_hu, op_st_h: return a[0];
            op_ld_w, op_st_w:           return a[1:0] != 2'b00;
            default:                    return 1'b0;
        endcase
    endfunction

    // little-endian bytes, then sign or zero extension
    function automatic logic [31:0] load_value(input int idx);
        logic [31:0]   full;
        logic [AW-1:0] a;
        logic [7:0]    b0;
        logic [7:0]    b1;
        full = addr_of(idx);
        a    = full[AW-1:0];
        b0   = model_mem[a];
        b1   = model_mem[a + AW'(1)];
        case (prog_op[idx])
            op_ld_b:  return {{24{b0[7]}}, b0};
            op_ld_bu: return {24'h0, b0};
            op_ld_h:  return {{16{b1[7]}}, b1, b0};
            op_ld_hu: return {16'h0, b1, b0};
            default:  return {model_mem[a + AW'(3)], model_mem[a + AW'(2)], b1, b0};
        endcase
    endfunction

    task automatic apply_store(input int idx);
        logic [31:0]   full;
        logic [AW-1:0] a;
        full = addr_of(idx);
        a    = full[AW-1:0];
        model_mem[a] = prog_wdata[idx][7:0];
        if (prog_op[idx] != op_st_b) begin
            model_mem[a + AW'(1)] = prog_wdata[idx][15:8];
        end
        if (prog_op[idx] == op_st_w) begin
            model_mem[a + AW'(2)] = prog_wdata[idx][23:16];
            model_mem[a + AW'(3)] = prog_wdata[idx][31:24];
        end
    endtask

    task automatic build_program();
        logic [31:0] a;
        int          k;
        for (int i = 0; i < PROG_LEN; i++) begin
            k             = {$random(seed)} % 9;
            prog_op[i]    = mem_op_t'(k[3:0]);
            prog_rd[i]    = 5'($random(seed));
            prog_wdata[i] = $random(seed);
            if (({$random(seed)} % 4) == 0) begin
                a = {$random(seed)} % MEM_BYTES;
            end else begin
                a = {$random(seed)} % WINDOW;
            end
            case (prog_op[i])
                op_ld_h, op_ld_hu, op_st_h: a[0] = (({$random(seed)} % 6) == 0);
                op_ld_w, op_st_w: begin
                    a[1:0] = 2'b00;
                    if (({$random(seed)} % 6) == 0) begin
                        a[1:0] = 2'(1 + {$random(seed)} % 3); // any nonzero offset
                    end
                end
                default: ;
            endcase
            if (prog_op[i] == op_add) begin
                prog_base[i] = $random(seed);
                prog_off[i]  = $random(seed);
            end else begin
                prog_off[i]  = {$random(seed)} % 256;
                prog_base[i] = a - prog_off[i];
            end
        end
    endtask

    task automatic check_retire(input string name, input logic [31:0] exp_pc,
                                input logic exp_we, input logic [4:0] exp_rd,
                                input logic [31:0] exp_data);
        if (wb_ex) begin
            stop_with_error($sformatf("%s raised an exception on an aligned access", name));
        end else if (retire_pc !== exp_pc) begin
            stop_with_error($sformatf("MISMATCH %s pc: expected %h, actual %h",
                                      name, exp_pc, retire_pc));
        end else if (retire_we !== exp_we) begin
            stop_with_error($sformatf("MISMATCH %s we: expected %b, actual %b",
                                      name, exp_we, retire_we));
        end else if (exp_we && retire_rd !== exp_rd) begin
            stop_with_error($sformatf("MISMATCH %s rd: expected %0d, actual %0d",
                                      name, exp_rd, retire_rd));
        end else if (exp_we && retire_wdata !== exp_data) begin
            stop_with_error($sformatf("MISMATCH %s data: expected %h, actual %h",
                                      name, exp_data, retire_wdata));
        end
    endtask

    task automatic check_ex(input string name, input logic [31:0] exp_pc);
        if (!wb_ex) begin
            stop_with_error($sformatf("%s is misaligned but raised no exception", name));
        end else if (ex_pc !== exp_pc) begin
            stop_with_error($sformatf("MISMATCH %s ex_pc: expected %h, actual %h",
                                      name, exp_pc, ex_pc));
        end else if (retire_we) begin
            stop_with_error($sformatf("%s wrote a register while excepting", name));
        end
    endtask

    // the data field only means something once the load is ready
    task automatic check_fwd(input string name, input rf_fwd_t exp, input rf_fwd_t act,
                             input bit with_data);
        if (act.pending !== exp.pending) begin
            stop_with_error($sformatf("MISMATCH %s pending: expected %b, actual %b",
                                      name, exp.pending, act.pending));
        end else if (act.rf_we !== exp.rf_we) begin
            stop_with_error($sformatf("MISMATCH %s rf_we: expected %b, actual %b",
                                      name, exp.rf_we, act.rf_we));
        end else if (act.rf_waddr !== exp.rf_waddr) begin
            stop_with_error($sformatf("MISMATCH %s rf_waddr: expected %0d, actual %0d",
                                      name, exp.rf_waddr, act.rf_waddr));
        end else if (with_data && act.rf_wdata !== exp.rf_wdata) begin
            stop_with_error($sformatf("MISMATCH %s rf_wdata: expected %h, actual %h",
                                      name, exp.rf_wdata, act.rf_wdata));
        end
    endtask

    // values stay put until accepted
    task automatic drive_input();
        if (!presenting && drv_idx < PROG_LEN && (({$random(seed)} % 4) != 0)) begin
            presenting = 1'b1;
            in_pc      = pc_of(drv_idx);
            in_op      = prog_op[drv_idx];
            in_base    = prog_base[drv_idx];
            in_offset  = prog_off[drv_idx];
            in_wdata   = prog_wdata[drv_idx];
            in_rd      = prog_rd[drv_idx];
        end
        in_valid = presenting;
    endtask

    task automatic take_retire(output bit flushed);
        int    idx;
        string name;
        flushed = 1'b0;
        if (fly_idx.size() == 0) begin
            stop_with_error("an instruction retired while none was in flight");
        end else begin
            idx  = fly_idx[0];
            name = name_of(idx);
            fly_idx.delete(0);
            fly_cyc.delete(0);
            n_retired++;
            if (misaligned(idx)) begin
                check_ex(name, pc_of(idx));
                n_ex++;
                fly_idx.delete();   // younger ones are gone
                fly_cyc.delete();
                drv_idx    = idx + 1;
                presenting = 1'b0;
                flushed    = 1'b1;
            end else begin
                case (prog_op[idx])
                    op_add: check_retire(name, pc_of(idx), 1'b1, prog_rd[idx], addr_of(idx));
                    op_st_b, op_st_h, op_st_w: begin
                        check_retire(name, pc_of(idx), 1'b0, prog_rd[idx], 32'h0);
                        apply_store(idx);
                    end
                    default: check_retire(name, pc_of(idx), 1'b1, prog_rd[idx],
                                          load_value(idx));
                endcase
            end
        end
    endtask

    // one observation per cycle, taken between the edges
    task automatic step_cycle();
        rf_fwd_t exp_fwd;
        bit      flushed;
        bit      with_data;
        cycle++;
        flushed = 1'b0;
        if (fly_idx.size() != 0 || presenting) begin
            stall++;
        end
        if (fwd_armed) begin // a waiting load leaves only once its data is there
            with_data = retire_valid && !misaligned(fwd_idx);
            exp_fwd   = '{pending: ~retire_valid, rf_we: 1'b1, rf_waddr: prog_rd[fwd_idx],
                          rf_wdata: load_value(fwd_idx)};
            check_fwd($sformatf("fwd %s", name_of(fwd_idx)), exp_fwd, fwd_snap, with_data);
            fwd_armed = 1'b0;
        end
        if (retire_valid) begin
            take_retire(flushed);
            stall = 0;
        end
        if (!flushed && in_valid && in_allowin) begin
            fly_idx.push_back(drv_idx);
            fly_cyc.push_back(cycle);
            drv_idx++;
            presenting = 1'b0;
            stall      = 0;
        end
        // oldest load, two cycles past accept, sits in the memory stage
        if (!flushed && fly_idx.size() != 0 && is_load(fly_idx[0])
                && cycle >= fly_cyc[0] + 2) begin
            fwd_snap  = fwd_out;
            fwd_idx   = fly_idx[0];
            fwd_armed = 1'b1;
        end
        if (stall > STALL_LIMIT) begin
            stop_with_error($sformatf("no accept or retire for %0d cycles", stall));
        end else if (cycle > CYCLE_LIMIT) begin
            stop_with_error("the program did not finish within the cycle limit");
        end
    endtask

    initial begin
        clk        = 1'b0;
        resetn     = 1'b0;
        in_valid   = 1'b0;
        in_pc      = 32'h0;
        in_op      = op_add;
        in_base    = 32'h0;
        in_offset  = 32'h0;
        in_wdata   = 32'h0;
        in_rd      = 5'd0;
        drv_idx    = 0;
        presenting = 1'b0;
        fwd_armed  = 1'b0;
        fwd_idx    = 0;
        cycle      = 0;
        stall      = 0;
        n_retired  = 0;
        n_ex       = 0;
        model_mem  = '{default: 8'h00};
        build_program();
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        while (drv_idx < PROG_LEN || fly_idx.size() != 0) begin
            @(negedge clk);
            drive_input();
            #1;
            step_cycle();
        end
        $display("%0d instructions retired, %0d exceptions", n_retired, n_ex);
        if (n_retired == PROG_LEN) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_with_error("the number of retired instructions differs from the program");
        end
    end
endmodule

/* source/mem_pipe_top.sv */
`timescale 1ns/1ps

module mem_pipe_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  in_valid,
    output logic                  in_allowin,
    input  logic [31:0]           in_pc,
    input  mem_op_pkg::mem_op_t   in_op,
    input  logic [31:0]           in_base,
    input  logic [31:0]           in_offset,
    input  logic [31:0]           in_wdata,
    input  logic [4:0]            in_rd,
    output logic                  retire_valid,
    output logic [31:0]           retire_pc,
    output logic                  retire_we,
    output logic [4:0]            retire_rd,
    output logic [31:0]           retire_wdata,
    output logic                  wb_ex,
    output logic [31:0]           ex_pc,
    output pipe_bus_pkg::rf_fwd_t fwd_out
);
    import pipe_bus_pkg::*;

    es2ms_bus_t  es2ms_bus;
    ms2ws_bus_t  ms2ws_bus;
    logic        es2ms_valid;
    logic        ms2ws_valid;
    logic        ms_allowin;
    logic        ws_allowin;
    logic        ms_ex;
    logic        sram_req;
    logic        sram_wr;
    logic [3:0]  sram_wstrb;
    logic [31:0] sram_addr;
    logic [31:0] sram_wdata;
    logic        sram_data_ok;
    logic [31:0] sram_rdata;

    exe_stage u_exe (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_allowin(in_allowin), .in_pc(in_pc), .in_op(in_op),
        .in_base(in_base), .in_offset(in_offset), .in_wdata(in_wdata), .in_rd(in_rd),
        .ms_allowin(ms_allowin), .ms_ex(ms_ex), .wb_ex(wb_ex),
        .es2ms_valid(es2ms_valid), .es2ms_bus(es2ms_bus),
        .data_sram_req(sram_req), .data_sram_wr(sram_wr), .data_sram_wstrb(sram_wstrb),
        .data_sram_addr(sram_addr), .data_sram_wdata(sram_wdata)
    );

    mem_stage u_mem (
        .clk(clk), .resetn(resetn),
        .ms_allowin(ms_allowin), .es2ms_valid(es2ms_valid), .es2ms_bus(es2ms_bus),
        .ws_allowin(ws_allowin), .ms2ws_valid(ms2ws_valid), .ms2ws_bus(ms2ws_bus),
        .ms_rf_fwd(fwd_out),
        .data_sram_data_ok(sram_data_ok), .data_sram_rdata(sram_rdata),
        .ms_ex(ms_ex), .wb_ex(wb_ex)
    );

    wb_stage u_wb (
        .clk(clk), .resetn(resetn),
        .ms2ws_valid(ms2ws_valid), .ms2ws_bus(ms2ws_bus), .ws_allowin(ws_allowin),
        .wb_ex(wb_ex), .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_we(retire_we), .retire_rd(retire_rd), .retire_wdata(retire_wdata),
        .ex_pc(ex_pc)
    );

    data_sram u_sram (
        .clk(clk), .resetn(resetn),
        .req(sram_req), .wr(sram_wr), .wstrb(sram_wstrb), .addr(sram_addr),
        .wdata(sram_wdata), .data_ok(sram_data_ok), .rdata(sram_rdata)
    );
endmodule

/* source/wb_stage.sv */
`timescale 1ns/1ps

module wb_stage (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     ms2ws_valid,
    input  pipe_bus_pkg::ms2ws_bus_t ms2ws_bus,
    output logic                     ws_allowin,
    output logic                     wb_ex,
    output logic                     retire_valid,
    output logic [31:0]              retire_pc,
    output logic                     retire_we,
    output logic [4:0]               retire_rd,
    output logic [31:0]              retire_wdata,
    output logic [31:0]              ex_pc
);
    import pipe_bus_pkg::*;

    ms2ws_bus_t ws_bus;
    logic       ws_valid;

    // the excepting entry leaves and whatever follows it is dropped
    pipe_slot #(.payload_t(ms2ws_bus_t)) u_slot (
        .clk        (clk),
        .resetn     (resetn),
        .flush      (wb_ex),
        .in_valid   (ms2ws_valid),
        .in_payload (ms2ws_bus),
        .allowin    (ws_allowin),
        .ready_go   (1'b1),
        .out_allowin(1'b1),       // nothing after writeback
        .out_valid  (ws_valid),
        .out_payload(ws_bus)
    );

    assign wb_ex = ws_valid & ws_bus.ex; // one cycle, slot empties on this edge
    assign ex_pc = ws_bus.pc;

    assign retire_valid = ws_valid;
    assign retire_pc    = ws_bus.pc;
    assign retire_we    = ws_valid & ws_bus.rf_we & ~ws_bus.ex;
    assign retire_rd    = ws_bus.rf_waddr;
    assign retire_wdata = ws_bus.rf_wdata;
endmodule

/* source/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input  logic                     clk,
    input  logic                     resetn,
    output logic                     ms_allowin,
    input  logic                     es2ms_valid,
    input  pipe_bus_pkg::es2ms_bus_t es2ms_bus,
    input  logic                     ws_allowin,
    output logic                     ms2ws_valid,
    output pipe_bus_pkg::ms2ws_bus_t ms2ws_bus,
    output pipe_bus_pkg::rf_fwd_t    ms_rf_fwd,
    input  logic                     data_sram_data_ok,
    input  logic [31:0]              data_sram_rdata,
    output logic                     ms_ex,
    input  logic                     wb_ex
);
    import pipe_bus_pkg::*;

    es2ms_bus_t  ms_bus;
    logic        ms_valid;
    logic        ms_wait_data_ok;
    logic        ms_ready_go;
    logic [31:0] ms_data_buf;
    logic        data_buf_valid;
    logic [31:0] ld_word;
    logic [31:0] shift_rdata;
    logic [31:0] ms_mem_result;
    logic [31:0] ms_rf_wdata;
    logic        sign_b;
    logic        sign_h;

    assign ms_wait_data_ok = ms_bus.wait_data_ok & ms_valid & ~wb_ex;
    assign ms_ready_go     = ~ms_wait_data_ok | data_sram_data_ok | data_buf_valid;
    assign ms_allowin      = ~ms_valid | (ms_ready_go & ws_allowin);
    assign ms2ws_valid     = ms_valid & ms_ready_go;
    assign ms_ex           = ms_valid & ms_bus.ale;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (wb_ex) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es2ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es2ms_valid && ms_allowin) begin
            ms_bus <= es2ms_bus;
        end
    end

    // keeps data_ok that shows up while writeback is not ready
    always_ff @(posedge clk) begin
        if (!resetn) begin
            data_buf_valid <= 1'b0;
        end else if ((ms2ws_valid && ws_allowin) || wb_ex) begin
            data_buf_valid <= 1'b0;
        end else if (!data_buf_valid && data_sram_data_ok && ms_valid) begin
            data_buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!data_buf_valid && data_sram_data_ok && ms_valid) begin
            ms_data_buf <= data_sram_rdata;
        end
    end

    assign ld_word     = data_buf_valid ? ms_data_buf : data_sram_rdata;
    assign shift_rdata = ld_word >> {ms_bus.result[1:0], 3'b000}; // lane to bit 0

    assign sign_b = ms_bus.ld_kind.b & shift_rdata[7];
    assign sign_h = ms_bus.ld_kind.h & shift_rdata[15];

    always_comb begin
        ms_mem_result[7:0] = shift_rdata[7:0];
        if (ms_bus.ld_kind.b || ms_bus.ld_kind.bu) begin
            ms_mem_result[15:8] = {8{sign_b}};
        end else begin
            ms_mem_result[15:8] = shift_rdata[15:8];
        end
        if (ms_bus.ld_kind.w) begin
            ms_mem_result[31:16] = shift_rdata[31:16];
        end else begin
            ms_mem_result[31:16] = {16{sign_b | sign_h}}; // zero for the unsigned kinds
        end
    end

    assign ms_rf_wdata = ms_bus.res_from_mem ? ms_mem_result : ms_bus.result;

    assign ms2ws_bus = '{pc: ms_bus.pc, rf_we: ms_bus.rf_we, rf_waddr: ms_bus.rf_waddr,
                         rf_wdata: ms_rf_wdata, ex: ms_ex};

    // pending marks a load whose value is not usable yet
    assign ms_rf_fwd = '{pending: ms_valid & ms_bus.res_from_mem & ~ms2ws_valid,
                         rf_we: ms_valid & ms_bus.rf_we,
                         rf_waddr: ms_bus.rf_waddr,
                         rf_wdata: ms_rf_wdata};
endmodule

/* source/exe_stage.sv */
`timescale 1ns/1ps

module exe_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    output logic                    in_allowin,
    input  logic [31:0]             in_pc,
    input  mem_op_pkg::mem_op_t     in_op,
    input  logic [31:0]             in_base,
    input  logic [31:0]             in_offset,
    input  logic [31:0]             in_wdata,
    input  logic [4:0]              in_rd,
    input  logic                    ms_allowin,
    input  logic                    ms_ex,
    input  logic                    wb_ex,
    output logic                    es2ms_valid,
    output pipe_bus_pkg::es2ms_bus_t es2ms_bus,
    output logic                    data_sram_req,
    output logic                    data_sram_wr,
    output logic [3:0]              data_sram_wstrb,
    output logic [31:0]             data_sram_addr,
    output logic [31:0]             data_sram_wdata
);
    import mem_op_pkg::*;

    typedef struct packed {
        logic [31:0] pc;
        mem_op_t     op;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] wdata;
        logic [4:0]  rd;
    } es_in_t;

    es_in_t    in_bundle;
    es_in_t    es;
    logic      es_valid;
    logic [31:0] es_addr;
    acc_size_t acc_size;
    ld_kind_t  ld_kind;
    logic      is_load;
    logic      is_store;
    logic      ale;
    logic      mem_go; // this op really talks to the SRAM

    assign in_bundle = '{pc: in_pc, op: in_op, base: in_base, offset: in_offset,
                         wdata: in_wdata, rd: in_rd};

    pipe_slot #(.payload_t(es_in_t)) u_slot (
        .clk        (clk),
        .resetn     (resetn),
        .flush      (wb_ex),
        .in_valid   (in_valid),
        .in_payload (in_bundle),
        .allowin    (in_allowin),
        .ready_go   (1'b1),
        .out_allowin(ms_allowin),
        .out_valid  (es_valid),
        .out_payload(es)
    );

    assign es_addr = es.base + es.offset;

    assign is_load  = es.op inside {op_ld_b, op_ld_bu, op_ld_h, op_ld_hu, op_ld_w};
    assign is_store = es.op inside {op_st_b, op_st_h, op_st_w};
    assign ld_kind  = '{b: es.op == op_ld_b, bu: es.op == op_ld_bu, h: es.op == op_ld_h,
                        hu: es.op == op_ld_hu, w: es.op == op_ld_w};

    always_comb begin
        case (es.op)
            op_ld_b, op_ld_bu, op_st_b: acc_size = size_byte;
            op_ld_h, op_ld_hu, op_st_h: acc_size = size_half;
            default:                    acc_size = size_word; // words and op_add
        endcase
    end

    assign ale = (acc_size == size_half && es_addr[0]) ||
                 (acc_size == size_word && (is_load || is_store) && es_addr[1:0] != 2'b00);

    assign mem_go = (is_load | is_store) & ~ale & ~ms_ex & ~wb_ex;

    always_comb begin
        case (acc_size)
            size_byte: begin
                data_sram_wstrb = 4'b0001 << es_addr[1:0];
                data_sram_wdata = {4{es.wdata[7:0]}};
            end
            size_half: begin
                data_sram_wstrb = 4'b0011 << {es_addr[1], 1'b0};
                data_sram_wdata = {2{es.wdata[15:0]}};
            end
            default: begin
                data_sram_wstrb = 4'b1111;
                data_sram_wdata = es.wdata;
            end
        endcase
    end

    assign data_sram_req  = es_valid & ms_allowin & mem_go; // only on the move into mem
    assign data_sram_wr   = is_store;
    assign data_sram_addr = es_addr;

    assign es2ms_valid = es_valid;
    assign es2ms_bus   = '{pc: es.pc, ld_kind: ld_kind, res_from_mem: is_load,
                           wait_data_ok: mem_go, rf_we: ~is_store, rf_waddr: es.rd,
                           result: es_addr, ale: ale};
endmodule

/* source/data_sram.sv */
`timescale 1ns/1ps
`include "mem_pipe_cfg.svh"

module data_sram (
    input  logic        clk,
    input  logic        resetn,
    input  logic        req,
    input  logic        wr,
    input  logic [3:0]  wstrb,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        data_ok,
    output logic [31:0] rdata
);
    localparam int IDX_W = $clog2(`MEM_PIPE_WORDS);
    localparam int CNT_W = $clog2(`MEM_PIPE_MAX_LAT + 1);

    logic [31:0]      mem [`MEM_PIPE_WORDS];
    logic [IDX_W-1:0] widx;
    logic [31:0]      rdata_r;
    logic             busy;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] lat;
    logic [7:0]       lfsr;
    logic             lfsr_fb;

    initial begin
        for (int i = 0; i < `MEM_PIPE_WORDS; i++) begin
            mem[i] = 32'h0;
        end
    end

    assign widx    = addr[IDX_W+1:2];
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign lat     = CNT_W'(lfsr % `MEM_PIPE_MAX_LAT) + CNT_W'(1); // 1 .. max

    assign data_ok = busy & (cnt == CNT_W'(1));
    assign rdata   = rdata_r;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= 8'h5a;
            busy <= 1'b0;
            cnt  <= '0;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
            if (req) begin // may land on the data_ok cycle of the previous one
                busy <= 1'b1;
                cnt  <= lat;
            end else if (busy) begin
                if (cnt == CNT_W'(1)) begin
                    busy <= 1'b0;
                end
                cnt <= cnt - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && wr) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[widx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (req && !wr) begin
            rdata_r <= mem[widx]; // held until data_ok
        end
    end
endmodule

/* source/pipe_slot.sv */
`timescale 1ns/1ps

module pipe_slot #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     allowin,
    input  logic     ready_go,
    input  logic     out_allowin,
    output logic     out_valid,
    output payload_t out_payload
);
    logic     valid;
    payload_t payload;

    assign allowin     = ~valid | (ready_go & out_allowin);
    assign out_valid   = valid & ready_go;
    assign out_payload = payload;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0; // flush wins over a new entry
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            payload <= in_payload;
        end
    end
endmodule

/* source/pipe_bus_pkg.sv */
package pipe_bus_pkg;

    // execute to memory
    typedef struct packed {
        logic [31:0]          pc;
        mem_op_pkg::ld_kind_t ld_kind;
        logic                 res_from_mem;
        logic                 wait_data_ok; // a request went out to the SRAM
        logic                 rf_we;
        logic [4:0]           rf_waddr;
        logic [31:0]          result;       // alu result, also the access address
        logic                 ale;
    } es2ms_bus_t;

    // memory to writeback
    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
        logic        ex;
    } ms2ws_bus_t;

    typedef struct packed {
        logic        pending; // load still waiting for its data
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
    } rf_fwd_t;

endpackage

/* source/mem_op_pkg.sv */
package mem_op_pkg;

    // operations seen by the execute stage
    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_ld_b  = 4'd1,
        op_ld_bu = 4'd2,
        op_ld_h  = 4'd3,
        op_ld_hu = 4'd4,
        op_ld_w  = 4'd5,
        op_st_b  = 4'd6,
        op_st_h  = 4'd7,
        op_st_w  = 4'd8
    } mem_op_t;

    // one-hot load kind, msb first in decode order
    typedef struct packed {
        logic b;
        logic bu;
        logic h;
        logic hu;
        logic w;
    } ld_kind_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } acc_size_t;

endpackage

/* include/mem_pipe_cfg.svh */
`ifndef MEM_PIPE_CFG_SVH
`define MEM_PIPE_CFG_SVH

// number of 32-bit words in the data SRAM
`define MEM_PIPE_WORDS 256

// largest request to data_ok delay, in cycles
`define MEM_PIPE_MAX_LAT 4

`endif
